// File: hw/seg_display_pkg.sv
package seg_display_pkg;

  localparam int unsigned NUM_DIGITS = 8; // digits on the board
  localparam int unsigned NIBBLE_W   = 4; // one hex digit

  // one digit as the 595 pair sees it, upper byte of the shifted word
  typedef struct packed {
    logic       dp;   // decimal point, msb
    logic [6:0] segs; // g..a, active high, common cathode
  } seg_t;

  localparam int unsigned WORD_W = $bits(seg_t) + NUM_DIGITS; // segments + select byte

  typedef struct packed {
    logic                                valid;   // one-cycle strobe
    logic [NUM_DIGITS-1:0][NIBBLE_W-1:0] nibbles; // [0] is debug32[3:0]
  } snap_t;

  function automatic logic [6:0] hex_to_seg(input logic [NIBBLE_W-1:0] nib);
    logic [6:0] pat;
    case (nib)
      4'h0: pat = 7'h3f;
      4'h1: pat = 7'h06;
      4'h2: pat = 7'h5b;
      4'h3: pat = 7'h4f;
      4'h4: pat = 7'h66;
      4'h5: pat = 7'h6d;
      4'h6: pat = 7'h7d;
      4'h7: pat = 7'h07;
      4'h8: pat = 7'h7f;
      4'h9: pat = 7'h6f;
      4'ha: pat = 7'h77;
      4'hb: pat = 7'h7c; // lower case b
      4'hc: pat = 7'h39;
      4'hd: pat = 7'h5e; // lower case d
      4'he: pat = 7'h79;
      default: pat = 7'h71; // F
    endcase
    return pat;
  endfunction

endpackage

// File: hw/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
  input  logic                   sys_clk,
  input  logic                   reset,
  input  logic [31:0]            debug32,     // from the processor system
  input  logic                   frame_done,  // serializer finished digit 7
  output seg_display_pkg::snap_t snap,        // snapshot to all digit cells
  output logic                   frame_start  // serializer may start
);

  logic pending_q; // start request left by reset
  logic take;      // snapshot on this edge
  logic valid_q;   // snap strobe
  logic start_q;   // snap strobe delayed one cycle

  logic [seg_display_pkg::NUM_DIGITS-1:0][seg_display_pkg::NIBBLE_W-1:0] nibbles_q;

  // a new frame is wanted after reset release and after each finished frame
  assign take = pending_q | frame_done;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      pending_q <= 1'b1; // first frame right after release
      valid_q   <= 1'b0;
      start_q   <= 1'b0;
    end else begin
      pending_q <= 1'b0;    // request served on the first free edge
      valid_q   <= take;    // one cycle, take never holds two cycles
      start_q   <= valid_q; // cells load on valid, so they are settled here
    end
  end

  // debug word is only sampled here, mid-frame changes wait for the next frame
  always_ff @(posedge sys_clk) begin
    if (take) begin
      nibbles_q <= debug32; // nibble 0 = bits 3:0
    end
  end

  assign snap.valid   = valid_q;
  assign snap.nibbles = nibbles_q;
  assign frame_start  = start_q;

endmodule

// File: hw/digit_cell.sv
`timescale 1ns/1ps

module digit_cell #(
  parameter int unsigned DP_HOLD_FRAMES = 3 // frames dp stays lit after a change
) (
  input  logic                                  sys_clk,
  input  logic                                  reset,
  input  logic                                  snap_valid, // new frame value present
  input  logic [seg_display_pkg::NIBBLE_W-1:0]  nibble,     // this digit's nibble
  output seg_display_pkg::seg_t                 seg         // pattern for the serializer
);

  localparam int unsigned HOLD_W =
    (DP_HOLD_FRAMES > 0) ? $clog2(DP_HOLD_FRAMES + 1) : 1;
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(DP_HOLD_FRAMES);

  logic [seg_display_pkg::NIBBLE_W-1:0] prev_q;  // nibble of the last frame
  logic [HOLD_W-1:0]                    hold_q;  // frames of dp left
  logic [HOLD_W-1:0]                    hold_nxt;
  logic                                 changed;
  seg_display_pkg::seg_t                seg_q;

  assign changed = (nibble != prev_q);

  // reload on change, otherwise run down and stick at zero
  always_comb begin
    hold_nxt = hold_q;
    if (changed) begin
      hold_nxt = HOLD_LOAD;
    end else if (hold_q != '0) begin
      hold_nxt = hold_q - 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      prev_q <= '0; // previous value counts as 0 after reset
      hold_q <= '0;
    end else if (snap_valid) begin
      prev_q <= nibble;
      hold_q <= hold_nxt;
    end
  end

  // pattern registered one cycle after snap_valid, held for the whole frame
  always_ff @(posedge sys_clk) begin
    if (snap_valid) begin
      seg_q.segs <= seg_display_pkg::hex_to_seg(nibble);
      seg_q.dp   <= (hold_nxt != '0); // current frame counts
    end
  end

  assign seg = seg_q;

endmodule

// File: hw/hc595_serializer.sv
`timescale 1ns/1ps

module hc595_serializer #(
  parameter int unsigned SHIFT_DIV = 4 // half period of segled_clk in sys_clk cycles
) (
  input  logic                                                     sys_clk,
  input  logic                                                     reset,
  input  logic                                                     frame_start,
  input  seg_display_pkg::seg_t [seg_display_pkg::NUM_DIGITS-1:0] digits,
  output logic                                                     segled_clk, // 595 SHCP
  output logic                                                     segled_dat, // 595 DS
  output logic                                                     segled_str, // 595 STCP
  output logic                                                     frame_done
);

  localparam int unsigned NDIG   = seg_display_pkg::NUM_DIGITS;
  localparam int unsigned WORD_W = seg_display_pkg::WORD_W;
  localparam int unsigned IDX_W  = $clog2(NDIG);
  localparam int unsigned BIT_W  = $clog2(WORD_W);
  localparam int unsigned DIV_W  = $clog2(2 * SHIFT_DIV);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SHIFT,
    S_STROBE
  } state_e;

  state_e            state_q;
  logic [DIV_W-1:0]  div_q;     // position inside a bit or a strobe
  logic [BIT_W-1:0]  bit_q;     // bits already sent of this word
  logic [IDX_W-1:0]  digit_q;   // digit being sent
  logic [WORD_W-1:0] shift_q;   // msb is on segled_dat
  logic              clk_q;
  logic              dat_q;
  logic              str_q;
  logic              done_q;

  logic              clk_rise;  // end of low half
  logic              bit_end;   // end of high half
  logic              str_end;   // last strobe cycle
  logic              last_bit;
  logic              last_digit;
  logic              load;      // new word goes out on this edge
  logic              advance;   // next bit of the same word
  logic [IDX_W-1:0]  load_idx;
  logic [NDIG-1:0]   load_sel;  // one-hot-low digit select
  logic [WORD_W-1:0] load_word;

  assign clk_rise   = (state_q == S_SHIFT) && (div_q == DIV_W'(SHIFT_DIV - 1));
  assign bit_end    = (state_q == S_SHIFT) && (div_q == DIV_W'(2 * SHIFT_DIV - 1));
  assign str_end    = (state_q == S_STROBE) && (div_q == DIV_W'(SHIFT_DIV - 1));
  assign last_bit   = (bit_q == BIT_W'(WORD_W - 1));
  assign last_digit = (digit_q == IDX_W'(NDIG - 1));

  assign load    = ((state_q == S_IDLE) && frame_start) || (str_end && !last_digit);
  assign advance = bit_end && !last_bit;

  // frames always begin at digit 0, later words take the next index
  assign load_idx  = (state_q == S_IDLE) ? '0 : digit_q + 1'b1;
  assign load_sel  = ~(NDIG'(1) << load_idx);
  assign load_word = {digits[load_idx], load_sel}; // segments first, select last

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state_q <= S_IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      digit_q <= '0;
      clk_q   <= 1'b0;
      str_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0; // single pulse
      div_q  <= div_q + 1'b1;
      case (state_q)
        S_IDLE: begin
          div_q <= '0;
          if (frame_start) begin
            state_q <= S_SHIFT;
            bit_q   <= '0;
            digit_q <= '0;
          end
        end
        S_SHIFT: begin
          if (clk_rise) begin
            clk_q <= 1'b1; // 595 samples dat here
          end
          if (bit_end) begin
            clk_q <= 1'b0;
            div_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (last_bit) begin
              state_q <= S_STROBE;
              str_q   <= 1'b1; // latch the full word
            end
          end
        end
        S_STROBE: begin
          if (str_end) begin
            str_q <= 1'b0;
            div_q <= '0;
            bit_q <= '0;
            if (last_digit) begin
              state_q <= S_IDLE;
              digit_q <= '0;
              done_q  <= 1'b1; // after the last strobe fell
            end else begin
              state_q <= S_SHIFT; // next digit, no gap
              digit_q <= digit_q + 1'b1;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      dat_q <= 1'b0; // pins low out of reset
    end else if (load) begin
      dat_q <= load_word[WORD_W-1];
    end else if (advance) begin
      dat_q <= shift_q[WORD_W-2]; // changes only as clk falls
    end
  end

  always_ff @(posedge sys_clk) begin
    if (load) begin
      shift_q <= load_word;
    end else if (advance) begin
      shift_q <= shift_q << 1; // msb first
    end
  end

  assign segled_clk = clk_q;
  assign segled_dat = dat_q;
  assign segled_str = str_q;
  assign frame_done = done_q;

endmodule

// File: hw/seg_display_top.sv
`timescale 1ns/1ps

module seg_display_top #(
  parameter int unsigned SHIFT_DIV      = 4, // serial clock half period
  parameter int unsigned DP_HOLD_FRAMES = 3  // dp highlight length in frames
) (
  input  logic        sys_clk,
  input  logic        reset,
  input  logic [31:0] debug32,    // debug word of the processor system
  output logic        segled_clk, // to the chained 74HC595 pair
  output logic        segled_dat,
  output logic        segled_str
);

  seg_display_pkg::snap_t snap;        // per-frame copy of debug32
  logic                   frame_start;
  logic                   frame_done;

  // one pattern per digit, index 0 is the lowest nibble
  seg_display_pkg::seg_t [seg_display_pkg::NUM_DIGITS-1:0] digits;

  frame_sequencer i_sequencer (
    .sys_clk     (sys_clk),
    .reset       (reset),
    .debug32     (debug32),
    .frame_done  (frame_done),
    .snap        (snap),
    .frame_start (frame_start)
  );

  for (genvar i = 0; i < seg_display_pkg::NUM_DIGITS; i++) begin : g_digit
    digit_cell #(
      .DP_HOLD_FRAMES (DP_HOLD_FRAMES)
    ) i_cell (
      .sys_clk    (sys_clk),
      .reset      (reset),
      .snap_valid (snap.valid),
      .nibble     (snap.nibbles[i]),
      .seg        (digits[i])
    );
  end

  hc595_serializer #(
    .SHIFT_DIV (SHIFT_DIV)
  ) i_serializer (
    .sys_clk     (sys_clk),
    .reset       (reset),
    .frame_start (frame_start),
    .digits      (digits),
    .segled_clk  (segled_clk),
    .segled_dat  (segled_dat),
    .segled_str  (segled_str),
    .frame_done  (frame_done) // back to the sequencer for the next snapshot
  );

endmodule

// File: dv/seg_display_checker.sv
`timescale 1ns/1ps

module seg_display_checker #(
  parameter int unsigned SHIFT_DIV = 4 // serial clock half period
) (
  input logic sys_clk,
  input logic reset,
  input logic segled_clk,
  input logic segled_dat,
  input logic segled_str
);

  logic        reset_q;    // reset seen on the previous edge
  int unsigned fail_count; // failed assertions so far

  initial fail_count = 0;

  always @(posedge sys_clk) begin
    reset_q <= reset;
  end

  // shift clock and latch strobe never overlap
  clk_str_exclusive: assert property (@(posedge sys_clk) disable iff (reset)
    !(segled_clk && segled_str))
    else begin
      $error("serial clock and strobe are high together");
      fail_count++;
    end

  // 595 samples on the rise, data must hold through the high half
  dat_stable_clk_high: assert property (@(posedge sys_clk) disable iff (reset)
    segled_clk |-> $stable(segled_dat))
    else begin
      $error("serial data moved while the serial clock was high");
      fail_count++;
    end

  strobe_width: assert property (@(posedge sys_clk) disable iff (reset)
    $rose(segled_str) |-> segled_str [*SHIFT_DIV] ##1 !segled_str)
    else begin
      $error("strobe width differs from the serial clock half period");
      fail_count++;
    end

  // all pins held low once reset has been seen for a full cycle
  quiet_in_reset: assert property (@(posedge sys_clk)
    (reset && reset_q) |-> (!segled_clk && !segled_str && !segled_dat))
    else begin
      $error("a serial pin is high during reset");
      fail_count++;
    end

endmodule

bind seg_display_top seg_display_checker #(
  .SHIFT_DIV (SHIFT_DIV)
) i_checker (
  .sys_clk    (sys_clk),
  .reset      (reset),
  .segled_clk (segled_clk),
  .segled_dat (segled_dat),
  .segled_str (segled_str)
);

// File: dv/seg_display_monitor.sv
`timescale 1ns/1ps

module seg_display_monitor #(
  parameter int unsigned DP_HOLD_FRAMES = 2 // frames dp stays lit after a change
) (
  input  logic        sys_clk,
  input  logic        reset,
  input  logic [31:0] debug32,      // stimulus as applied by the testbench
  input  logic        segled_clk,
  input  logic        segled_dat,
  input  logic        segled_str,
  output int          strobe_count, // words latched in the current frame
  output int          frame_count,  // frames completed
  output int          error_count,
  output logic [15:0] nibble_seen   // one bit per hex value shown
);

  localparam int NDIG = seg_display_pkg::NUM_DIGITS;

  // g..a patterns, common cathode, 0-9 then A b C d E F
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
  };

  logic        clk_prev;   // serial clock on the last edge
  logic        str_prev;
  logic        started;    // first serial clock seen
  logic [15:0] word;       // bits of the word in flight, msb first
  int          bit_count;
  logic [31:0] frame_val;  // debug word the current frame must show
  logic [3:0]  prev_nib [NDIG];
  int          age [NDIG]; // frames since the digit last changed
  bit          dp_exp [NDIG];

  initial begin
    strobe_count = 0;
    frame_count  = 0;
    error_count  = 0;
    nibble_seen  = '0;
  end

  task automatic report(input string check, input int digit,
                        input logic [15:0] expected, input logic [15:0] actual);
    $display("[ERROR] %s, digit %0d: expected %0h, actual %0h", check, digit, expected, actual);
    error_count++;
  endtask

  // dp lit while the last change is less than DP_HOLD_FRAMES frames old
  task automatic update_dp_model();
    logic [3:0] nib;
    for (int d = 0; d < NDIG; d++) begin
      nib = frame_val[4*d +: 4];
      if (nib != prev_nib[d]) begin
        age[d] = 0; // this frame counts
      end else if (age[d] < int'(DP_HOLD_FRAMES)) begin
        age[d]++;
      end
      prev_nib[d] = nib;
      dp_exp[d]   = (age[d] < int'(DP_HOLD_FRAMES));
    end
  endtask

  task automatic close_word();
    seg_display_pkg::seg_t seg;
    logic [3:0]            nib;
    logic [7:0]            sel;
    if (strobe_count == 0) begin
      update_dp_model(); // frame begins with digit 0
    end
    seg = word[15:8];
    nib = frame_val[4*strobe_count +: 4];
    sel = 8'hff;
    sel[strobe_count] = 1'b0; // zero only at the digit index
    if (bit_count != 16) report("framing", strobe_count, 16'd16, 16'(bit_count));
    if (seg.segs != SEG_TABLE[nib]) report("segments", strobe_count, SEG_TABLE[nib], seg.segs);
    if (seg.dp != dp_exp[strobe_count]) report("decimal point", strobe_count,
                                                dp_exp[strobe_count], seg.dp);
    if (word[7:0] != sel) report("scan order", strobe_count, sel, word[7:0]);
    nibble_seen[nib] = 1'b1;
    strobe_count++;
    if (strobe_count == NDIG) begin
      strobe_count = 0;
      frame_count++;
      frame_val = debug32; // next snapshot, stimulus only moves mid frame
    end
    bit_count = 0;
    word      = '0;
  endtask

  always @(posedge sys_clk) begin
    if (reset) begin
      if ((segled_clk | segled_str | segled_dat) === 1'b1) begin
        $display("a serial pin is high during reset");
        error_count++;
      end
      clk_prev     = 1'b0;
      str_prev     = 1'b0;
      started      = 1'b0;
      bit_count    = 0;
      word         = '0;
      strobe_count = 0;
      frame_val    = debug32; // value at release is the first frame
      for (int d = 0; d < NDIG; d++) begin
        prev_nib[d] = '0;
        age[d]      = int'(DP_HOLD_FRAMES);
      end
    end else begin
      if (!started && segled_str) begin
        $display("strobe raised before the first serial clock");
        error_count++;
      end
      if (segled_clk && !clk_prev) begin
        started = 1'b1;
        if (segled_str) begin
          $display("serial clock rose during a strobe");
          error_count++;
        end
        word = {word[14:0], segled_dat}; // data valid through the high half
        bit_count++;
      end
      if (segled_str && !str_prev) begin
        close_word();
      end
      clk_prev = segled_clk;
      str_prev = segled_str;
    end
  end

endmodule

// File: dv/tb_seg_display.sv
`timescale 1ns/1ps

module tb_seg_display;

  localparam int unsigned SHIFT_DIV      = 2;
  localparam int unsigned DP_HOLD_FRAMES = 2;
  localparam int          NUM_FRAMES     = 60;
  localparam int          WAIT_LIMIT     = 2000; // cycles, one frame is about 530

  logic        sys_clk;
  logic        reset;
  logic [31:0] debug32;
  logic        segled_clk;
  logic        segled_dat;
  logic        segled_str;

  int          strobes_seen;  // from the monitor
  int          frames_seen;
  int          compare_errors;
  logic [15:0] nibbles_seen;

  integer      seed;
  int          timeout_errors;
  int          coverage_errors;
  int          assert_errors; // from the bound protocol checker
  bit          aborted;       // a wait ran out

  initial sys_clk = 1'b0;
  always #10 sys_clk = ~sys_clk; // 20 ns period

  seg_display_top #(
    .SHIFT_DIV      (SHIFT_DIV),
    .DP_HOLD_FRAMES (DP_HOLD_FRAMES)
  ) i_dut (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .debug32    (debug32),
    .segled_clk (segled_clk),
    .segled_dat (segled_dat),
    .segled_str (segled_str)
  );

  seg_display_monitor #(
    .DP_HOLD_FRAMES (DP_HOLD_FRAMES)
  ) i_monitor (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .debug32      (debug32),
    .segled_clk   (segled_clk),
    .segled_dat   (segled_dat),
    .segled_str   (segled_str),
    .strobe_count (strobes_seen),
    .frame_count  (frames_seen),
    .error_count  (compare_errors),
    .nibble_seen  (nibbles_seen)
  );

  // returns 2 ns after a rising edge, ready to drive
  task automatic wait_for_strobes(input int count);
    int cycles;
    cycles = 0;
    while (strobes_seen < count && cycles < WAIT_LIMIT) begin
      @(posedge sys_clk);
      #2;
      cycles++;
    end
    if (strobes_seen < count) begin
      $display("timeout waiting for strobe %0d of frame %0d", count, frames_seen);
      timeout_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_for_frame_end(input int target);
    int cycles;
    cycles = 0;
    while (frames_seen < target && cycles < WAIT_LIMIT) begin
      @(posedge sys_clk);
      #2;
      cycles++;
    end
    if (frames_seen < target) begin
      $display("timeout waiting for the end of frame %0d", target - 1);
      timeout_errors++;
      aborted = 1'b1;
    end
  endtask

  // random word, single nibble flip, then two held frames
  task automatic apply_word(input int frame);
    int         digit;
    logic [3:0] flip;
    case (frame % 4)
      0: debug32 = $random(seed);
      1: begin
        digit   = {$random(seed)} % 8;
        flip    = 4'({$random(seed)} % 15 + 1); // nonzero, digit always changes
        debug32 = debug32 ^ (32'(flip) << (4 * digit));
      end
      default: ; // held, dp runs out
    endcase
  endtask

  initial begin
    seed            = 52152;
    reset           = 1'b1;
    debug32         = $random(seed); // shown by the first frame
    timeout_errors  = 0;
    coverage_errors = 0;
    assert_errors   = 0;
    aborted         = 1'b0;
    repeat (16) @(posedge sys_clk);
    #2;
    reset = 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      wait_for_strobes(4);
      if (aborted) break;
      apply_word(f); // mid frame, only the next frame may show it
      wait_for_frame_end(f + 1);
      if (aborted) break;
    end
    if (!aborted && nibbles_seen != 16'hffff) begin
      $display("not every hex value was displayed, seen mask %h", nibbles_seen);
      coverage_errors++;
    end
    assert_errors = int'(i_dut.i_checker.fail_count);
    $display("%0d frames, errors: %0d compare, %0d timeout, %0d coverage, %0d assertion",
             frames_seen, compare_errors, timeout_errors, coverage_errors, assert_errors);
    if (compare_errors + timeout_errors + coverage_errors + assert_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: seg_display.f
hw/seg_display_pkg.sv
hw/frame_sequencer.sv
hw/digit_cell.sv
hw/hc595_serializer.sv
hw/seg_display_top.sv
dv/seg_display_checker.sv
dv/seg_display_monitor.sv
dv/tb_seg_display.sv

// File: Bender.yml
package:
  name: seg_display

sources:
  - files:
      - hw/seg_display_pkg.sv
      - hw/frame_sequencer.sv
      - hw/digit_cell.sv
      - hw/hc595_serializer.sv
      - hw/seg_display_top.sv
  - target: test
    files:
      - dv/seg_display_checker.sv
      - dv/seg_display_monitor.sv
      - dv/tb_seg_display.sv
